/* files.f */
+incdir+include
hdl/fifoPkg.sv
hdl/userFifoDual.sv
hdl/grayPtrSync.sv
hdl/fifoDualController.sv
hdl/fifoDualTop.sv
testbench/tbFifoDual.sv

/* hdl/fifoDualController.sv */
`timescale 1ns/1ps

`include "fifo_params.svh"

// dual clock fifo control
// write domain on iCLKA, read domain on iCLKB
// pointers cross as gray code and each flag is local to its domain
module fifoDualController import fifoPkg::*; (
    input  logic    iCLKA,   // write clock
    input  logic    iCLKB,   // read clock
    input  logic    rst,     // sync reset held on both clocks
    input  wrReq_t  wrReq,   // write strobe and data
    output logic    full,    // registered in the write domain
    input  logic    rdEn,    // read strobe
    output logic    empty,   // registered in the read domain
    output rdBeat_t rdBeat   // data beat three read clocks after accept
);

    localparam int LAT = `FIFO_RD_LATENCY;

    // ------------------------------------------------------------
    // signals
    // ------------------------------------------------------------
    ptr_t wrPtr;        // write domain
    ptr_t rdPtrSync;    // read pointer seen in the write domain
    ptr_t wrDiff;       // words in flight as seen by the writer
    ptr_t rdPtr;        // read domain
    ptr_t wrPtrSync;    // write pointer seen in the read domain

    logic wrAccept;
    logic rdAccept;
    logic fullNow;      // unregistered compare for acceptance
    logic emptyNow;

    logic                        ramWe;       // input register stage
    logic [`FIFO_ADDR_WIDTH-1:0] ramWrAddr;
    logic [`FIFO_DATA_WIDTH-1:0] ramWrData;
    logic [`FIFO_ADDR_WIDTH-1:0] ramRdAddr;   // read stage 1
    logic [`FIFO_DATA_WIDTH-1:0] ramRdData;   // read stage 2

    logic [LAT-2:0]              validPipe;   // tracks stages 1 and 2
    logic                        outValid;    // stage 3
    logic [`FIFO_DATA_WIDTH-1:0] outData;

    // ------------------------------------------------------------
    // write domain
    // ------------------------------------------------------------
    assign wrDiff   = wrPtr - rdPtrSync;
    assign fullNow  = (wrDiff == ptr_t'(`FIFO_DEPTH));
    assign wrAccept = wrReq.en && !fullNow;   // dropped when full

    always_ff @(posedge iCLKA)
    begin
        if (rst)
        begin
            wrPtr <= '0;
            ramWe <= 1'b0;
            full  <= 1'b0;
        end
        else
        begin
            if (wrAccept)
            begin
                wrPtr <= wrPtr + 1'b1;
            end
            ramWe <= wrAccept;   // ram written on the following edge
            full  <= fullNow;
        end
    end

    // address and word captured with the pointer step
    always_ff @(posedge iCLKA)
    begin
        if (wrAccept)
        begin
            ramWrAddr <= wrPtr[`FIFO_ADDR_WIDTH-1:0];
            ramWrData <= wrReq.data;
        end
    end

    // ------------------------------------------------------------
    // read domain
    // ------------------------------------------------------------
    assign emptyNow = (rdPtr == wrPtrSync);
    assign rdAccept = rdEn && !emptyNow;      // dropped when empty

    always_ff @(posedge iCLKB)
    begin
        if (rst)
        begin
            rdPtr     <= '0;
            empty     <= 1'b1;
            validPipe <= '0;
            outValid  <= 1'b0;
        end
        else
        begin
            if (rdAccept)
            begin
                rdPtr <= rdPtr + 1'b1;
            end
            empty     <= emptyNow;
            validPipe <= {validPipe[LAT-3:0], rdAccept};  // follows the ram path
            outValid  <= validPipe[LAT-2];
        end
    end

    // stage 1 holds the read index until the next accepted read
    always_ff @(posedge iCLKB)
    begin
        if (rdAccept)
        begin
            ramRdAddr <= rdPtr[`FIFO_ADDR_WIDTH-1:0];
        end
    end

    // stage 3 output word only moves with a valid beat
    always_ff @(posedge iCLKB)
    begin
        if (validPipe[LAT-2])
        begin
            outData <= ramRdData;
        end
    end

    assign rdBeat = '{valid: outValid, data: outData};

    // ------------------------------------------------------------
    // storage and pointer crossings
    // ------------------------------------------------------------
    userFifoDual #(
        .pDepth     (`FIFO_DEPTH),
        .pWidth     (`FIFO_DATA_WIDTH),
        .pAddrWidth (`FIFO_ADDR_WIDTH)
    ) ram_i (
        .iCLKA  (iCLKA),
        .iCLKB  (iCLKB),
        .we     (ramWe),
        .wrAddr (ramWrAddr),
        .wrData (ramWrData),
        .rdAddr (ramRdAddr),
        .rdData (ramRdData)          // stage 2
    );

    // write pointer into the read domain
    grayPtrSync wrSync_i (
        .srcClk (iCLKA),
        .dstClk (iCLKB),
        .rst    (rst),
        .srcPtr (wrPtr),
        .dstPtr (wrPtrSync)
    );

    // read pointer into the write domain
    grayPtrSync rdSync_i (
        .srcClk (iCLKB),
        .dstClk (iCLKA),
        .rst    (rst),
        .srcPtr (rdPtr),
        .dstPtr (rdPtrSync)
    );

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    // compared against the live pointer of the other domain
    // the synchronized copy may only lag it
    aNoWriteWhenFull : assert property (
        @(posedge iCLKA) disable iff (rst)
        wrAccept |-> ((wrPtr - rdPtr) != ptr_t'(`FIFO_DEPTH))
    ) else $error("write accepted with fifo full");

    aNoReadWhenEmpty : assert property (
        @(posedge iCLKB) disable iff (rst)
        rdAccept |-> (rdPtr != wrPtr)
    ) else $error("read accepted with fifo empty");

    // holds only if the read pointer crossing never runs ahead of the writer
    aWrNeverOverruns : assert property (
        @(posedge iCLKA) disable iff (rst)
        wrDiff <= ptr_t'(`FIFO_DEPTH)
    ) else $error("write pointer more than depth ahead of read pointer");

endmodule

/* hdl/fifoDualTop.sv */
`timescale 1ns/1ps

// subsystem boundary of the dual clock fifo
// write side on iCLKA, read side on iCLKB
module fifoDualTop import fifoPkg::*; (
    input  logic    iCLKA,   // write clock
    input  logic    iCLKB,   // read clock
    input  logic    rst,     // sync reset, active high
    input  wrReq_t  wrReq,   // write request
    output logic    full,    // write side flag
    input  logic    rdEn,    // read request
    output logic    empty,   // read side flag
    output rdBeat_t rdBeat   // read data beat
);

    // ------------------------------------------------------------
    // controller
    // ------------------------------------------------------------
    // pointers, flags and the ram all live below this level

    fifoDualController ctrl_i (
        // clocks and reset
        .iCLKA  (iCLKA),
        .iCLKB  (iCLKB),
        .rst    (rst),

        // write side
        .wrReq  (wrReq),
        .full   (full),

        // read side
        .rdEn   (rdEn),
        .empty  (empty),
        .rdBeat (rdBeat)
    );

endmodule

/* hdl/fifoPkg.sv */
`include "fifo_params.svh"

package fifoPkg;

    // ------------------------------------------------------------
    // pointers
    // ------------------------------------------------------------
    // one bit above the ram index, wraps every second pass
    // so full and empty can be told apart
    typedef logic [`FIFO_ADDR_WIDTH:0] ptr_t;

    // ------------------------------------------------------------
    // port bundles
    // ------------------------------------------------------------
    // write side request, sampled on iCLKA
    typedef struct packed {
        logic                        en;    // write strobe
        logic [`FIFO_DATA_WIDTH-1:0] data;  // word to store
    } wrReq_t;

    // read side beat, driven from iCLKB
    typedef struct packed {
        logic                        valid; // one cycle per accepted read
        logic [`FIFO_DATA_WIDTH-1:0] data;  // word leaving the fifo
    } rdBeat_t;

endpackage

/* hdl/grayPtrSync.sv */
`timescale 1ns/1ps

// moves a pointer between clock domains
// binary -> gray in srcClk, two flops in dstClk, gray -> binary
module grayPtrSync import fifoPkg::*; #(
    parameter int pWidth = $bits(ptr_t)   // pointer width incl wrap bit
) (
    input  logic srcClk,   // clock of the pointer owner
    input  logic dstClk,   // clock of the consumer
    input  logic rst,      // sync reset, sampled on both clocks
    input  ptr_t srcPtr,   // binary pointer, source domain
    output ptr_t dstPtr    // binary pointer, destination domain
);

    logic [pWidth-1:0] graySrc;    // launched from a flop, never from logic
    logic [pWidth-1:0] syncMeta;   // first stage, may go metastable
    logic [pWidth-1:0] syncOut;    // second stage, safe to decode

    function automatic logic [pWidth-1:0] grayToBin(input logic [pWidth-1:0] g);
        logic [pWidth-1:0] b;
        b[pWidth-1] = g[pWidth-1];
        for (int i = pWidth - 2; i >= 0; i--)
        begin
            b[i] = b[i+1] ^ g[i];   // running xor from the msb down
        end
        return b;
    endfunction

    always_ff @(posedge srcClk)
    begin
        if (rst)
        begin
            graySrc <= '0;
        end
        else
        begin
            graySrc <= srcPtr ^ (srcPtr >> 1);   // binary to gray
        end
    end

    always_ff @(posedge dstClk)
    begin
        if (rst)
        begin
            syncMeta <= '0;
            syncOut  <= '0;
        end
        else
        begin
            syncMeta <= graySrc;
            syncOut  <= syncMeta;
        end
    end

    assign dstPtr = ptr_t'(grayToBin(syncOut));

    // the crossing is only safe while the source moves by one code at a time
    aGraySingleStep : assert property (
        @(posedge srcClk) disable iff (rst)
        $countones(graySrc ^ $past(graySrc)) <= 1
    ) else $error("gray source changed more than one bit");

endmodule

/* hdl/userFifoDual.sv */
`timescale 1ns/1ps

`include "fifo_params.svh"

// simple dual port ram, write on iCLKA, read on iCLKB
// read port registered so the array maps onto block ram
module userFifoDual #(
    parameter int pDepth     = `FIFO_DEPTH,       // entries
    parameter int pWidth     = `FIFO_DATA_WIDTH,  // bits per entry
    parameter int pAddrWidth = `FIFO_ADDR_WIDTH   // index bits
) (
    input  logic                  iCLKA,   // write clock
    input  logic                  iCLKB,   // read clock
    input  logic                  we,      // write enable
    input  logic [pAddrWidth-1:0] wrAddr,  // write index
    input  logic [pWidth-1:0]     wrData,  // write word
    input  logic [pAddrWidth-1:0] rdAddr,  // read index
    output logic [pWidth-1:0]     rdData   // registered read word
);

    // storage array, contents undefined until written
    logic [pWidth-1:0] mem [pDepth];

    // ------------------------------------------------------------
    // write port
    // ------------------------------------------------------------
    always_ff @(posedge iCLKA)
    begin
        if (we)
        begin
            mem[wrAddr] <= wrData;   // one word per clock
        end
    end

    // ------------------------------------------------------------
    // read port
    // ------------------------------------------------------------
    always_ff @(posedge iCLKB)
    begin
        rdData <= mem[rdAddr];       // one clock from address to data
    end

endmodule

/* include/fifo_params.svh */
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// ------------------------------------------------------------
// data path sizing
// ------------------------------------------------------------
`define FIFO_DATA_WIDTH 32                  // bits per stored word

// depth must stay a power of two
// the pointer wrap bit relies on it
`define FIFO_DEPTH      16
`define FIFO_ADDR_WIDTH $clog2(`FIFO_DEPTH) // ram index width

// ------------------------------------------------------------
// read side timing
// ------------------------------------------------------------
// accepted read to valid beat, in read clocks
// stages are addr reg, ram out reg, output reg
`define FIFO_RD_LATENCY 3

`endif

/* run.sh */
#!/bin/sh
# build and run the dual clock fifo testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=tbFifoDual
BUILD=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found on PATH"
    exit 1
fi

rm -rf "$BUILD" "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -Mdir "$BUILD" -f files.f
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit $status
fi

"./$BUILD/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

# the log decides the result
if grep -q "STATUS: FAIL" "$LOG"; then
    echo "testbench reported failure, see $LOG"
    exit 1
fi

echo "simulation finished without reported failure"
exit 0

/* testbench/tbFifoDual.sv */
`timescale 1ns/1ps

`include "fifo_params.svh"

// testbench for the dual clock fifo
// write side on a 10 ns clock, read side on 14 ns so the edges drift
module tbFifoDual import fifoPkg::*; ();

    localparam int LAT   = `FIFO_RD_LATENCY;
    localparam int DEPTH = `FIFO_DEPTH;
    localparam int SB_AW = 10;                   // scoreboard ring index bits

    logic    iCLKA = 1'b0;
    logic    iCLKB = 1'b0;
    logic    rst;
    wrReq_t  wrReq;
    logic    full;
    logic    rdEn;
    logic    empty;
    rdBeat_t rdBeat;

    int errResetRd = 0;
    int errResetWr = 0;
    int errOrder   = 0;
    int errLatency = 0;
    int errFull    = 0;
    int errEmpty   = 0;
    int errCount   = 0;                          // drain and fill totals
    int errTimeout = 0;

    // ------------------------------------------------------------
    // expected pointers, flags and scoreboard
    // ------------------------------------------------------------
    logic [`FIFO_DATA_WIDTH-1:0] sbData [2**SB_AW];   // ring indexed by running counts
    logic [31:0]    wrCount;                     // writes accepted
    logic [31:0]    wrSrc;                       // launch reg in the write domain
    logic [31:0]    wrSync1;                     // read domain stages
    logic [31:0]    wrSync2;
    logic [31:0]    rdCount;                     // reads accepted
    logic [31:0]    rdSrc;
    logic [31:0]    rdSync1;                     // write domain stages
    logic [31:0]    rdSync2;
    logic [31:0]    beatCount;                   // valid beats popped
    logic           fullExp;
    logic           emptyExp;
    logic [LAT-1:0] latPipe;                     // accepted reads in flight
    logic           wrTake;
    logic           rdTake;
    logic [`FIFO_DATA_WIDTH-1:0] headData;

    // acceptance follows the pointer compare since the flags lag a cycle
    assign wrTake   = wrReq.en && (wrCount - rdSync2 != DEPTH);
    assign rdTake   = rdEn && (rdCount != wrSync2);
    assign headData = sbData[beatCount[SB_AW-1:0]];

    always #5 iCLKA = ~iCLKA;                    // 10 ns
    always #7 iCLKB = ~iCLKB;                    // 14 ns

    fifoDualTop dut_i (
        .iCLKA  (iCLKA),
        .iCLKB  (iCLKB),
        .rst    (rst),
        .wrReq  (wrReq),
        .full   (full),
        .rdEn   (rdEn),
        .empty  (empty),
        .rdBeat (rdBeat)
    );

    always @(posedge iCLKA)
    begin
        if (rst)
        begin
            wrCount <= '0;
            wrSrc   <= '0;
            rdSync1 <= '0;
            rdSync2 <= '0;
            fullExp <= 1'b0;
        end
        else
        begin
            if (wrTake)
            begin
                sbData[wrCount[SB_AW-1:0]] <= wrReq.data;   // push
                wrCount <= wrCount + 1;
            end
            wrSrc   <= wrCount;
            rdSync1 <= rdSrc;
            rdSync2 <= rdSync1;
            fullExp <= (wrCount - rdSync2 == DEPTH);
        end
    end

    always @(posedge iCLKB)
    begin
        if (rst)
        begin
            rdCount   <= '0;
            rdSrc     <= '0;
            wrSync1   <= '0;
            wrSync2   <= '0;
            beatCount <= '0;
            emptyExp  <= 1'b1;
            latPipe   <= '0;
        end
        else
        begin
            if (rdTake)
            begin
                rdCount <= rdCount + 1;
            end
            if (rdBeat.valid)
            begin
                beatCount <= beatCount + 1;      // pop
            end
            rdSrc    <= rdCount;
            wrSync1  <= wrSrc;
            wrSync2  <= wrSync1;
            emptyExp <= (rdCount == wrSync2);
            latPipe  <= {latPipe[LAT-2:0], rdTake};
        end
    end

    task automatic reportFail(input string msg, inout int errs);
        $display("FAIL %0d ns: %s", $time, msg);
        errs++;
    endtask

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    aResetRd : assert property (
        @(posedge iCLKB) ($past(rst) && !rst) |-> (empty && !rdBeat.valid)
    ) else reportFail("read side not idle after reset", errResetRd);

    aResetWr : assert property (
        @(posedge iCLKA) ($past(rst) && !rst) |-> !full
    ) else reportFail("full set after reset", errResetWr);

    aOrder : assert property (
        @(posedge iCLKB) disable iff (rst)
        rdBeat.valid |-> ((beatCount != wrCount) && (rdBeat.data == headData))
    ) else reportFail("beat data differs from scoreboard head", errOrder);

    aLatency : assert property (
        @(posedge iCLKB) disable iff (rst) rdBeat.valid == latPipe[LAT-1]
    ) else reportFail("valid beat not three reads after accept", errLatency);

    aFullFlag : assert property (
        @(posedge iCLKA) disable iff (rst) full == fullExp
    ) else reportFail("full flag differs from pointer compare", errFull);

    aEmptyFlag : assert property (
        @(posedge iCLKB) disable iff (rst) empty == emptyExp
    ) else reportFail("empty flag differs from pointer compare", errEmpty);

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic runRandom(input int wrPct, input int rdPct,
                             input int wrCycles, input int rdCycles);
        fork
            begin
                repeat (wrCycles)
                begin
                    @(posedge iCLKA);
                    wrReq.en   <= int'($urandom % 100) < wrPct;
                    wrReq.data <= $urandom;
                end
                @(posedge iCLKA);
                wrReq.en <= 1'b0;
            end
            begin
                repeat (rdCycles)
                begin
                    @(posedge iCLKB);
                    rdEn <= int'($urandom % 100) < rdPct;
                end
                @(posedge iCLKB);
                rdEn <= 1'b0;
            end
        join
    endtask

    task automatic drainFifo();
        logic [31:0] queued;
        logic [31:0] startBeats;
        int          waitCycles;
        repeat (8) @(posedge iCLKB);             // crossings and read pipe settle
        queued     = wrCount - beatCount;
        startBeats = beatCount;
        waitCycles = 0;
        @(posedge iCLKB);
        rdEn <= 1'b1;
        while (!empty && waitCycles < 200)
        begin
            @(posedge iCLKB);
            waitCycles++;
        end
        if (waitCycles >= 200)
        begin
            $display("timeout: fifo did not go empty while draining");
            errTimeout++;
        end
        rdEn <= 1'b0;
        repeat (LAT + 2) @(posedge iCLKB);       // last beats leave the pipe
        assert (beatCount - startBeats == queued)
        else reportFail("drain beat count differs from queued words", errCount);
        assert (empty)
        else reportFail("empty low after drain", errCount);
    endtask

    task automatic fillFifo();
        logic [31:0] startWrites;
        int          waitCycles;
        repeat (8) @(posedge iCLKA);             // read pointer crossing settles
        startWrites = wrCount;
        waitCycles  = 0;
        while (!full && waitCycles < 200)
        begin
            @(posedge iCLKA);
            wrReq.en   <= 1'b1;
            wrReq.data <= $urandom;
            waitCycles++;
        end
        if (waitCycles >= 200)
        begin
            $display("timeout: fifo did not go full while filling");
            errTimeout++;
        end
        repeat (4)
        begin
            @(posedge iCLKA);
            wrReq.data <= $urandom;              // offered while full and dropped
        end
        @(posedge iCLKA);
        wrReq.en <= 1'b0;
        repeat (4) @(posedge iCLKA);
        assert (wrCount - startWrites == DEPTH)
        else reportFail("fill did not take exactly depth words", errCount);
    endtask

    initial
    begin
        int total;
        rst   = 1'b1;
        wrReq = '0;
        rdEn  = 1'b0;
        void'($urandom(32'h8f6c));
        repeat (10) @(posedge iCLKB);
        rst <= 1'b0;
        repeat (4) @(posedge iCLKB);
        runRandom(67, 50, 400, 286);             // writes outpace reads
        runRandom(25, 90, 400, 286);             // reads outpace writes
        drainFifo();
        fillFifo();
        drainFifo();
        total = errResetRd + errResetWr + errOrder + errLatency + errFull + errEmpty
              + errCount + errTimeout;
        $display("errors: reset %0d/%0d order %0d lat %0d full %0d empty %0d count %0d tmo %0d",
                 errResetRd, errResetWr, errOrder, errLatency, errFull, errEmpty,
                 errCount, errTimeout);
        if (total == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
